/* Bender.yml */
package:
  name: floo_router

sources:
  - src/floo_pkg.sv
  - src/floo_link_if.sv
  - src/floo_in_fifo.sv
  - src/floo_route_select.sv
  - src/floo_wormhole_arbiter.sv
  - src/floo_router.sv
  - target: simulation
    files:
      - testbench/tb_floo_router.sv

/* files.f */
src/floo_pkg.sv
src/floo_link_if.sv
src/floo_in_fifo.sv
src/floo_route_select.sv
src/floo_wormhole_arbiter.sv
src/floo_router.sv
testbench/tb_floo_router.sv

/* src/floo_in_fifo.sv */
/*
  Input flit FIFO, circular buffer without fall-through.
  A flit written at one edge is visible on the output after that edge.
  ready_o only drops when all Depth entries are in use. Depth must be 1 or more.
*/
`timescale 1ns/1ps

module floo_in_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  output logic            ready_o,
  input  floo_pkg::flit_t data_i,
  floo_link_if.tx         out_if
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);

  floo_pkg::flit_t         mem [Depth];
  logic [PtrWidth-1:0]     wr_ptr_q;
  logic [PtrWidth-1:0]     rd_ptr_q;
  logic [CntWidth-1:0]     count_q;
  logic                    push;
  logic                    pop;

  assign ready_o = (count_q != CntWidth'(Depth));
  assign push    = valid_i & ready_o;
  assign pop     = out_if.valid & out_if.ready;

  // Head entry straight from storage
  assign out_if.valid = (count_q != '0);
  assign out_if.last  = mem[rd_ptr_q].last;
  assign out_if.word  = mem[rd_ptr_q].word;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* src/floo_link_if.sv */
/*
  One flit link with a valid/ready handshake.
  A flit moves on a clock edge where valid and ready are both high.
  The sender keeps valid, last and word stable until that edge.
*/
`timescale 1ns/1ps

interface floo_link_if;

  logic                  valid;
  logic                  ready;
  logic                  last;
  floo_pkg::flit_word_u  word;

  // Sending side of the link
  modport tx (
    output valid,
    output last,
    output word,
    input  ready
  );

  // Receiving side of the link
  modport rx (
    input  valid,
    input  last,
    input  word,
    output ready
  );

endinterface

/* src/floo_pkg.sv */
/*
  Shared types for the 2D mesh router.
  Coordinates are unsigned, so the grid is at most 16 x 16 routers.
  A flit word is read as a header only on the first flit of a packet.
*/
package floo_pkg;

  // Width of one grid coordinate
  localparam int unsigned CoordWidth = 4;

  // Width of one flit word
  localparam int unsigned DataWidth = 32;

  // Local port plus the four mesh neighbours
  localparam int unsigned NumPorts = 5;

  // Bits left over in the header after both addresses
  localparam int unsigned RsvdWidth = DataWidth - 4 * CoordWidth;

  // Port directions, also used as array index at the router boundary
  typedef enum logic [2:0] {
    Eject = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  // Grid position of a router or an endpoint
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

  // Header view of a head flit
  typedef struct packed {
    xy_id_t               dst;
    xy_id_t               src;
    logic [RsvdWidth-1:0] rsvd;
  } hdr_t;

  // Same 32 bits, seen as header or as plain payload
  typedef union packed {
    hdr_t                 hdr;
    logic [DataWidth-1:0] payload;
  } flit_word_u;

  // One flit on a link, last marks the tail of the packet
  typedef struct packed {
    logic       last;
    flit_word_u word;
  } flit_t;

endpackage

/* src/floo_route_select.sv */
/*
  Dimension-ordered XY route selection, X first then Y.
  The route of a packet comes from its head flit and is kept until the last flit.
  The first flit after reset is taken as a head flit.
*/
`timescale 1ns/1ps

module floo_route_select (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  floo_pkg::xy_id_t              xy_id_i,
  floo_link_if.rx                       in_if,
  input  logic                          ready_i,
  output logic [floo_pkg::NumPorts-1:0] route_o
);

  logic [floo_pkg::NumPorts-1:0] route_q;
  logic [floo_pkg::NumPorts-1:0] head_route;
  floo_pkg::route_dir_e          head_dir;
  floo_pkg::hdr_t                hdr;
  logic                          is_head;
  logic                          xfer;

  // Ready comes from the output that this input currently targets
  assign in_if.ready = ready_i;
  assign xfer        = in_if.valid & ready_i;

  // No held route means the next flit opens a packet
  assign is_head = (route_q == '0);
  assign hdr     = in_if.word.hdr;

  always_comb begin
    head_dir = floo_pkg::Eject;
    if (hdr.dst.x > xy_id_i.x) begin
      head_dir = floo_pkg::East;
    end else if (hdr.dst.x < xy_id_i.x) begin
      head_dir = floo_pkg::West;
    end else if (hdr.dst.y > xy_id_i.y) begin
      head_dir = floo_pkg::North;
    end else if (hdr.dst.y < xy_id_i.y) begin
      head_dir = floo_pkg::South;
    end
  end

  always_comb begin
    head_route           = '0;
    head_route[head_dir] = 1'b1;
  end

  assign route_o = is_head ? head_route : route_q;

  // Hold the route for body flits, drop it with the tail
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      route_q <= '0;
    end else if (xfer) begin
      if (in_if.last) begin
        route_q <= '0;
      end else if (is_head) begin
        route_q <= head_route;
      end
    end
  end

endmodule

/* src/floo_router.sv */
/*
  Five-port 2D mesh router, XY routing, wormhole switching, one channel.
  Loopback and Y-to-X turns are not wired; such a flit stalls at its input.
  Ports are indexed by floo_pkg::route_dir_e. InFifoDepth must be 1 or more.
*/
`timescale 1ns/1ps

module floo_router #(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  floo_pkg::xy_id_t                         xy_id_i,
  input  logic [floo_pkg::NumPorts-1:0]            valid_i,
  output logic [floo_pkg::NumPorts-1:0]            ready_o,
  input  floo_pkg::flit_t [floo_pkg::NumPorts-1:0] data_i,
  output logic [floo_pkg::NumPorts-1:0]            valid_o,
  input  logic [floo_pkg::NumPorts-1:0]            ready_i,
  output floo_pkg::flit_t [floo_pkg::NumPorts-1:0] data_o
);

  localparam int unsigned NumPorts = floo_pkg::NumPorts;

  // Route masks and returned readies, indexed [input][output]
  logic [NumPorts-1:0][NumPorts-1:0] route_mask;
  logic [NumPorts-1:0][NumPorts-1:0] ready_t;
  logic [NumPorts-1:0]               in_ready;

  // Arbiter side, indexed [output][input]
  logic            [NumPorts-1:0][NumPorts-1:0] arb_req;
  logic            [NumPorts-1:0][NumPorts-1:0] arb_ready;
  floo_pkg::flit_t [NumPorts-1:0][NumPorts-1:0] arb_data;

  floo_link_if in_link  [NumPorts] ();
  floo_link_if out_link [NumPorts] ();

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    floo_in_fifo #(
      .Depth ( InFifoDepth )
    ) i_in_fifo (
      .clk_i    ( clk_i      ),
      .arst_n_i ( arst_n_i   ),
      .valid_i  ( valid_i[i] ),
      .ready_o  ( ready_o[i] ),
      .data_i   ( data_i[i]  ),
      .out_if   ( in_link[i] )
    );

    floo_route_select i_route_select (
      .clk_i    ( clk_i         ),
      .arst_n_i ( arst_n_i      ),
      .xy_id_i  ( xy_id_i       ),
      .in_if    ( in_link[i]    ),
      .ready_i  ( in_ready[i]   ),
      .route_o  ( route_mask[i] )
    );

    // Only the arbiter on the selected output can accept the flit
    assign in_ready[i] = |(ready_t[i] & route_mask[i]);
  end

  for (genvar i = 0; i < NumPorts; i++) begin : gen_cross_in
    for (genvar o = 0; o < NumPorts; o++) begin : gen_cross_out
      if ((i == o) ||
          (((i == int'(floo_pkg::North)) || (i == int'(floo_pkg::South))) &&
           ((o == int'(floo_pkg::East)) || (o == int'(floo_pkg::West))))) begin : gen_no_conn
        assign arb_req[o][i]  = 1'b0;
        assign arb_data[o][i] = '0;
        assign ready_t[i][o]  = 1'b0;
      end else begin : gen_conn
        assign arb_req[o][i]            = in_link[i].valid & route_mask[i][o];
        assign arb_data[o][i].last      = in_link[i].last;
        assign arb_data[o][i].word      = in_link[i].word;
        assign ready_t[i][o]            = arb_ready[o][i];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    floo_wormhole_arbiter #(
      .NumInputs ( NumPorts )
    ) i_wormhole_arbiter (
      .clk_i    ( clk_i        ),
      .arst_n_i ( arst_n_i     ),
      .req_i    ( arb_req[o]   ),
      .data_i   ( arb_data[o]  ),
      .ready_o  ( arb_ready[o] ),
      .out_if   ( out_link[o]  )
    );

    assign valid_o[o]        = out_link[o].valid;
    assign data_o[o].last    = out_link[o].last;
    assign data_o[o].word    = out_link[o].word;
    assign out_link[o].ready = ready_i[o];
  end

endmodule

/* src/floo_wormhole_arbiter.sv */
/*
  Round-robin output arbiter with wormhole locking.
  Once a flit is offered the grant stays on that input until the tail flit
  has passed, so valid and data hold under back-pressure. NumInputs must be 2 or more.
*/
`timescale 1ns/1ps

module floo_wormhole_arbiter #(
  parameter int unsigned NumInputs = floo_pkg::NumPorts
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [NumInputs-1:0]            req_i,
  input  floo_pkg::flit_t [NumInputs-1:0] data_i,
  output logic [NumInputs-1:0]            ready_o,
  floo_link_if.tx                         out_if
);

  localparam int unsigned IdxWidth = $clog2(NumInputs);
  localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumInputs - 1);

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic                lock_q;
  logic [IdxWidth-1:0] rr_idx;
  logic [IdxWidth-1:0] gnt_idx;
  logic                xfer;

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    idx    = 0;
    found  = 1'b0;
    rr_idx = ptr_q;
    for (int unsigned k = 0; k < NumInputs; k++) begin
      idx = (int'(ptr_q) + k) % NumInputs;
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        rr_idx = IdxWidth'(idx);
      end
    end
  end

  assign gnt_idx = lock_q ? lock_idx_q : rr_idx;

  // A locked output only listens to its owner
  assign out_if.valid = lock_q ? req_i[lock_idx_q] : |req_i;
  assign out_if.last  = data_i[gnt_idx].last;
  assign out_if.word  = data_i[gnt_idx].word;
  assign xfer         = out_if.valid & out_if.ready;

  always_comb begin
    ready_o          = '0;
    ready_o[gnt_idx] = out_if.ready & req_i[gnt_idx];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      ptr_q      <= '0;
    end else begin
      if (xfer && out_if.last) begin
        lock_q <= 1'b0;
        // Next packet starts looking one past the winner
        ptr_q  <= (gnt_idx == LastIdx) ? '0 : gnt_idx + 1'b1;
      end else if (out_if.valid) begin
        // Stalled flit or open packet keeps the grant
        lock_q     <= 1'b1;
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

/* testbench/tb_floo_router.sv */
/*
  Testbench for the mesh router placed at grid position (2,2).
  Head flits carry the sending input port in rsvd[15:13] so each output can
  sort flits back to their source. Packets never use loopback or Y-to-X turns.
*/
`timescale 1ns/1ps

module tb_floo_router;

  localparam int NumPorts = floo_pkg::NumPorts;
  localparam int FlitTimeout = 400;
  localparam int DrainTimeout = 3000;

  logic                                     clk;
  logic                                     arst_n;
  floo_pkg::xy_id_t                         xy_id;
  logic [NumPorts-1:0]                      in_valid;
  logic [NumPorts-1:0]                      in_ready;
  floo_pkg::flit_t [NumPorts-1:0]           in_data;
  logic [NumPorts-1:0]                      out_valid;
  logic [NumPorts-1:0]                      out_ready;
  floo_pkg::flit_t [NumPorts-1:0]           out_data;

  integer              seed;
  int                  pkt_seq;
  logic [NumPorts-1:0] stall_hold;
  logic [NumPorts-1:0] stall_rand;
  logic [NumPorts-1:0] in_pkt;
  int                  cur_src [NumPorts];

  // Expected flits, one queue per output and source input, index o*NumPorts+i
  floo_pkg::flit_t exp_q [NumPorts*NumPorts][$];

  floo_router #(
    .InFifoDepth ( 2 )
  ) uut (
    .clk_i    ( clk       ),
    .arst_n_i ( arst_n    ),
    .xy_id_i  ( xy_id     ),
    .valid_i  ( in_valid  ),
    .ready_o  ( in_ready  ),
    .data_i   ( in_data   ),
    .valid_o  ( out_valid ),
    .ready_i  ( out_ready ),
    .data_o   ( out_data  )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  endtask

  task automatic give_up(input string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  // XY rule: X first, then Y, otherwise local delivery
  function automatic int xy_port(input floo_pkg::xy_id_t dst);
    if (int'(dst.x) > 2) return 2;
    if (int'(dst.x) < 2) return 4;
    if (int'(dst.y) > 2) return 1;
    if (int'(dst.y) < 2) return 3;
    return 0;
  endfunction

  // No loopback and no turn from North/South onto East/West
  function automatic bit link_allowed(input int in_port, input int out_port);
    if (in_port == out_port) return 1'b0;
    if ((in_port == 1 || in_port == 3) && (out_port == 2 || out_port == 4)) return 1'b0;
    return 1'b1;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int q = 0; q < NumPorts * NumPorts; q++) begin
      total += exp_q[q].size();
    end
    return total;
  endfunction

  task automatic send_packet(input int port, input floo_pkg::xy_id_t dst, input int len);
    floo_pkg::flit_t flits [$];
    floo_pkg::flit_t f;
    int              out_port;
    int              wait_cnt;
    bit              taken;
    out_port = xy_port(dst);
    for (int k = 0; k < len; k++) begin
      f = '0;
      if (k == 0) begin
        f.word.hdr.dst   = dst;
        f.word.hdr.src   = floo_pkg::xy_id_t'(rand_below(256));
        f.word.hdr.rsvd  = {port[2:0], pkt_seq[12:0]};
      end else begin
        f.word.payload = $random(seed);
      end
      f.last = (k == len - 1);
      flits.push_back(f);
      exp_q[out_port*NumPorts+port].push_back(f);
    end
    pkt_seq++;
    @(posedge clk);
    #5;
    for (int k = 0; k < len; k++) begin
      in_valid[port] = 1'b1;
      in_data[port]  = flits[k];
      taken          = 1'b0;
      wait_cnt       = 0;
      while (!taken) begin
        @(negedge clk);
        taken = in_ready[port];
        @(posedge clk);
        #5;
        wait_cnt++;
        if (!taken && wait_cnt > FlitTimeout) begin
          give_up($sformatf("input %0d never accepted flit %0d of its packet", port, k));
        end
      end
    end
    in_valid[port] = 1'b0;
  endtask

  task automatic random_traffic(input int port, input int count);
    floo_pkg::xy_id_t dst;
    int               tries;
    for (int n = 0; n < count; n++) begin
      tries = 0;
      do begin
        dst.x = 4'(rand_below(5));
        dst.y = 4'(rand_below(5));
        tries++;
      end while (!link_allowed(port, xy_port(dst)) && tries < 100);
      if (!link_allowed(port, xy_port(dst))) begin
        give_up($sformatf("no legal destination drawn for input %0d", port));
      end
      send_packet(port, dst, 1 + rand_below(4));
      repeat (rand_below(3)) @(posedge clk);
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (pending() != 0) begin
      @(negedge clk);
      cnt++;
      if (cnt > DrainTimeout) begin
        give_up($sformatf("%0d expected flits never left the router", pending()));
      end
    end
  endtask

  // Output ready pattern, changed shortly after each rising edge
  always @(posedge clk) begin : ready_drive
    logic [31:0] r;
    #5;
    for (int o = 0; o < NumPorts; o++) begin
      r = $random(seed);
      if (stall_hold[o]) begin
        out_ready[o] = 1'b0;
      end else if (stall_rand[o]) begin
        out_ready[o] = r[0];
      end else begin
        out_ready[o] = 1'b1;
      end
    end
  end

  // Scoreboard, sampled mid-cycle where all DUT outputs are settled
  always @(negedge clk) begin : scoreboard
    floo_pkg::flit_t exp;
    int              src;
    int              qi;
    if (arst_n) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          if (!in_pkt[o]) begin
            cur_src[o] = int'(out_data[o].word.hdr.rsvd[15:13]);
          end
          src = cur_src[o];
          assert (src < NumPorts && link_allowed(src, o))
          else give_up($sformatf("output %0d carried a flit from illegal input %0d", o, src));
          qi = o * NumPorts + src;
          assert (exp_q[qi].size() != 0)
          else give_up($sformatf("output %0d delivered an unexpected flit from input %0d",
                                 o, src));
          exp = exp_q[qi].pop_front();
          assert (out_data[o] == exp)
          else show_mismatch($sformatf("data_o[%0d]", o), 64'(out_data[o]), 64'(exp));
          in_pkt[o] = !out_data[o].last;
        end
      end
    end
  end

  // A stalled output keeps its flit
  for (genvar o = 0; o < NumPorts; o++) begin : gen_stall_check
    assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid[o] && !out_ready[o]) |=> (out_valid[o] && $stable(out_data[o])))
    else give_up($sformatf("output %0d dropped valid_o or changed data_o (now 0x%h) while stalled",
                           o, out_data[o]));
  end

  initial begin
    floo_pkg::xy_id_t dst;
    int               wait_cnt;
    seed       = 32'h8fbe;
    pkt_seq    = 0;
    arst_n     = 1'b0;
    xy_id.x    = 4'd2;
    xy_id.y    = 4'd2;
    in_valid   = '0;
    in_data    = '0;
    out_ready  = '1;
    stall_hold = '0;
    stall_rand = '0;
    in_pkt     = '0;
    repeat (2) @(posedge clk);
    #5;
    arst_n = 1'b1;

    // Reset state
    @(negedge clk);
    assert (out_valid == '0) else show_mismatch("valid_o", 64'(out_valid), 64'h0);
    assert (in_ready == '1) else show_mismatch("ready_o", 64'(in_ready), 64'h1f);

    // Single flits in every direction from every input
    for (int p = 0; p < NumPorts; p++) begin
      for (int d = 0; d < 7; d++) begin
        case (d)
          0: begin dst.x = 4'd3; dst.y = 4'd2; end
          1: begin dst.x = 4'd1; dst.y = 4'd2; end
          2: begin dst.x = 4'd2; dst.y = 4'd4; end
          3: begin dst.x = 4'd2; dst.y = 4'd0; end
          4: begin dst.x = 4'd2; dst.y = 4'd2; end
          5: begin dst.x = 4'd7; dst.y = 4'd0; end
          default: begin dst.x = 4'd0; dst.y = 4'd9; end
        endcase
        if (link_allowed(p, xy_port(dst))) begin
          send_packet(p, dst, 1);
          wait_drain();
        end
      end
    end

    // Two packets race for East, local and West inputs
    dst.x = 4'd5;
    dst.y = 4'd2;
    fork
      send_packet(4, dst, 3);
      send_packet(0, dst, 3);
    join
    wait_drain();

    // Hold East low until the West FIFO fills, then release at random
    stall_hold[2] = 1'b1;
    fork
      send_packet(4, dst, 6);
      begin
        wait_cnt = 0;
        do begin
          @(negedge clk);
          wait_cnt++;
          if (wait_cnt > 50) begin
            give_up("ready_o of the West input stayed high with East stalled");
          end
        end while (in_ready[4]);
        repeat (3) @(negedge clk);
        assert (out_valid[2]) else show_mismatch("valid_o[2]", 64'(out_valid[2]), 64'h1);
        stall_hold[2] = 1'b0;
        stall_rand[2] = 1'b1;
      end
    join
    wait_drain();

    // Random packets on all inputs with random back-pressure everywhere
    stall_rand = '1;
    fork
      random_traffic(0, 8);
      random_traffic(1, 8);
      random_traffic(2, 8);
      random_traffic(3, 8);
      random_traffic(4, 8);
    join
    wait_drain();
    stall_rand = '0;

    // Router idle with every input FIFO empty
    repeat (2) @(negedge clk);
    if (out_valid != '0) begin
      show_mismatch("valid_o", 64'(out_valid), 64'h0);
    end else if (in_ready != '1) begin
      show_mismatch("ready_o", 64'(in_ready), 64'h1f);
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule
